/* include/uberclock_consts.svh */
`ifndef UBERCLOCK_CONSTS_SVH
`define UBERCLOCK_CONSTS_SVH

// ------------------------------
// channel structure
// ------------------------------
// rx/tx channel pairs in the mixer
`define UC_NUM_CHAN 5

// ------------------------------
// sample widths
// ------------------------------
// downsampled i/q and tx chain output
`define UC_SAMPLE_W 16
// raw adc word
`define UC_ADC_W 12
// dac data bus
`define UC_DAC_W 14
// unsigned per channel gain
`define UC_GAIN_W 32
// arithmetic shift after gain product
`define UC_GAIN_SHIFT 30

// ------------------------------
// sum tree and dac
// ------------------------------
// five 16 bit samples need 19 bits
`define UC_SUM_W 19
// low bits dropped going to 14 bits
`define UC_SUM_DROP 5
// offset binary zero point of the dac
`define UC_DAC_MIDSCALE 8192
// loopback left shift control
`define UC_SHIFT_W 3

`endif

/* rtl/dac_output_select.sv */
`timescale 1ns/1ns
`include "uberclock_consts.svh"

module dac_output_select (
    input  logic                        sys_clk,
    input  logic                        rst,
    input  uberclock_pkg::dac_src_e     i_sel,
    input  uberclock_pkg::dac_sources_t i_src,
    // offset binary word for the dac
    output logic [`UC_DAC_W-1:0]        o_dac
);

    import uberclock_pkg::*;

    // two's complement zero maps here
    localparam logic [`UC_DAC_W-1:0] DAC_MID = `UC_DAC_W'(`UC_DAC_MIDSCALE);
    // 16 bit sources drop this many lsbs
    localparam int SAMP_LSB = `UC_SAMPLE_W - `UC_DAC_W;

    logic [3:0]           tx_code;
    logic [`UC_DAC_W-1:0] pick;
    logic [`UC_DAC_W-1:0] dac_q;

    // tx codes start at 5
    assign tx_code = i_sel - DAC_TX0;

    // ------------------------------
    // source select
    // ------------------------------
    always_comb begin
        case (i_sel)
            DAC_GAIN_Y0, DAC_GAIN_Y1, DAC_GAIN_Y2, DAC_GAIN_Y3, DAC_GAIN_Y4: begin
                // code is the channel index
                pick = i_src.gain_y[i_sel[2:0]][`UC_SAMPLE_W-1:SAMP_LSB];
            end
            DAC_TX0, DAC_TX1, DAC_TX2, DAC_TX3, DAC_TX4: begin
                pick = i_src.tx_sample[tx_code[2:0]][`UC_SAMPLE_W-1:SAMP_LSB];
            end
            DAC_ADC0: begin
                // 12 bit adc moved up to full scale
                pick = {i_src.adc[0], 2'b00};
            end
            DAC_ADC1: begin
                pick = {i_src.adc[1], 2'b00};
            end
            default: begin
                // code 10 and 13 to 15
                pick = i_src.sum_trunc;
            end
        endcase
    end

    // ------------------------------
    // output register
    // ------------------------------
    // adding midscale flips to offset binary, wraps mod 2^14
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            dac_q <= DAC_MID;
        end else begin
            dac_q <= pick + DAC_MID;
        end
    end

    assign o_dac = dac_q;

endmodule

/* rtl/rx_source_select.sv */
`timescale 1ns/1ns
`include "uberclock_consts.svh"

module rx_source_select (
    input  logic                        sys_clk,
    input  logic                        rst,
    // raw offset binary adc words
    input  logic [`UC_ADC_W-1:0]        i_adc_ch0,
    input  logic [`UC_ADC_W-1:0]        i_adc_ch1,
    // receive chain input choice
    input  logic                        i_use_loopback,
    input  logic signed [`UC_DAC_W-1:0] i_loopback,
    // two's complement adc samples
    output logic signed [`UC_ADC_W-1:0] o_adc_ch0,
    output logic signed [`UC_ADC_W-1:0] o_adc_ch1,
    output logic signed [`UC_ADC_W-1:0] o_rx_input
);

    // loopback keeps the top 12 of 14 bits
    localparam int LB_LSB = `UC_DAC_W - `UC_ADC_W;

    logic signed [`UC_ADC_W-1:0] adc_q0;
    logic signed [`UC_ADC_W-1:0] adc_q1;

    // ------------------------------
    // adc capture
    // ------------------------------
    // offset binary to two's complement
    // flipping the msb is all it takes
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            adc_q0 <= '0;
            adc_q1 <= '0;
        end else begin
            adc_q0 <= {~i_adc_ch0[`UC_ADC_W-1], i_adc_ch0[`UC_ADC_W-2:0]};
            adc_q1 <= {~i_adc_ch1[`UC_ADC_W-1], i_adc_ch1[`UC_ADC_W-2:0]};
        end
    end

    assign o_adc_ch0 = adc_q0;
    assign o_adc_ch1 = adc_q1;

    // ------------------------------
    // receive input select
    // ------------------------------
    // loopback drops two lsbs, sign stays in place
    always_comb begin
        if (i_use_loopback) begin
            o_rx_input = i_loopback[`UC_DAC_W-1:LB_LSB];
        end else begin
            o_rx_input = adc_q0;
        end
    end

endmodule

/* rtl/tx_feed.sv */
`timescale 1ns/1ns
`include "uberclock_consts.svh"

module tx_feed (
    // downsampled pair from the rx chain
    input  uberclock_pkg::iq_sample_t       i_rx,
    // unsigned gain, 2^30 is unity
    input  logic [`UC_GAIN_W-1:0]           i_gain,
    // pair written by the cpu
    input  uberclock_pkg::iq_sample_t       i_cpu,
    input  logic                            i_src_cpu,
    // feed toward the tx chain
    output uberclock_pkg::iq_sample_t       o_feed,
    // gained y for the dac selectors
    output logic signed [`UC_SAMPLE_W-1:0]  o_gain_y
);

    import uberclock_pkg::*;

    // sample times gain plus the zero sign bit
    localparam int PROD_W = `UC_SAMPLE_W + `UC_GAIN_W + 1;

    logic signed [`UC_GAIN_W:0] gain_s;
    logic signed [PROD_W-1:0]   prod_x;
    logic signed [PROD_W-1:0]   prod_y;
    logic signed [PROD_W-1:0]   shift_x;
    logic signed [PROD_W-1:0]   shift_y;
    iq_sample_t                 gained;

    // ------------------------------
    // gain scaling
    // ------------------------------
    // leading zero keeps the gain positive in a signed multiply
    assign gain_s = {1'b0, i_gain};

    assign prod_x = i_rx.x * gain_s;
    assign prod_y = i_rx.y * gain_s;

    // scale back down, sign preserved
    assign shift_x = prod_x >>> `UC_GAIN_SHIFT;
    assign shift_y = prod_y >>> `UC_GAIN_SHIFT;

    // low 16 bits only, large gains wrap
    assign gained.x = shift_x[`UC_SAMPLE_W-1:0];
    assign gained.y = shift_y[`UC_SAMPLE_W-1:0];

    // ------------------------------
    // feed select
    // ------------------------------
    // cpu pair is shared by all channels
    assign o_feed = i_src_cpu ? i_cpu : gained;

    // dac sees the gained y whatever feeds the tx chain
    assign o_gain_y = gained.y;

endmodule

/* rtl/tx_sum_tree.sv */
`timescale 1ns/1ns
`include "uberclock_consts.svh"

module tx_sum_tree (
    input  logic                                              sys_clk,
    input  logic                                              rst,
    // tx chain outputs, each element is two's complement
    input  logic signed [`UC_NUM_CHAN-1:0][`UC_SAMPLE_W-1:0]  i_tx_sample,
    input  logic [`UC_SHIFT_W-1:0]                            i_final_shift,
    // top 14 bits of the total, 3 cycles after the samples
    output logic signed [`UC_DAC_W-1:0]                       o_sum_trunc,
    // registered truncated sum, shifted
    output logic signed [`UC_DAC_W-1:0]                       o_loopback
);

    // one growth bit per adder level
    localparam int S1_W = `UC_SAMPLE_W + 1;
    localparam int S2_W = `UC_SAMPLE_W + 2;

    logic signed [S1_W-1:0]      pair01_q;
    logic signed [S1_W-1:0]      pair23_q;
    logic signed [S1_W-1:0]      samp4_q;
    logic signed [S2_W-1:0]      quad_q;
    logic signed [S2_W-1:0]      samp4_qq;
    logic signed [`UC_SUM_W-1:0] total_q;
    logic signed [`UC_DAC_W-1:0] trunc_q;

    // ------------------------------
    // stage 1
    // ------------------------------
    // two pair sums, sample 4 rides along sign extended
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            pair01_q <= '0;
            pair23_q <= '0;
            samp4_q  <= '0;
        end else begin
            pair01_q <= $signed(i_tx_sample[0]) + $signed(i_tx_sample[1]);
            pair23_q <= $signed(i_tx_sample[2]) + $signed(i_tx_sample[3]);
            samp4_q  <= $signed(i_tx_sample[4]);
        end
    end

    // ------------------------------
    // stage 2 and 3
    // ------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            quad_q   <= '0;
            samp4_qq <= '0;
            total_q  <= '0;
        end else begin
            quad_q   <= pair01_q + pair23_q;
            samp4_qq <= samp4_q;
            // full 19 bit total, cannot overflow
            total_q  <= quad_q + samp4_qq;
        end
    end

    // plain truncation, no rounding
    assign o_sum_trunc = total_q[`UC_SUM_W-1:`UC_SUM_DROP];

    // ------------------------------
    // output register and shift
    // ------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            trunc_q <= '0;
        end else begin
            trunc_q <= o_sum_trunc;
        end
    end

    // left shift wraps inside 14 bits, no saturation
    assign o_loopback = trunc_q << i_final_shift;

endmodule

/* rtl/uberclock.sv */
`timescale 1ns/1ns
`include "uberclock_consts.svh"

module uberclock (
    input  logic                                              sys_clk,
    input  logic                                              rst,

    // raw adc words, offset binary
    input  logic [`UC_ADC_W-1:0]                              i_adc_ch0,
    input  logic [`UC_ADC_W-1:0]                              i_adc_ch1,
    // 1 feeds the summed output back into rx
    input  logic                                              i_use_loopback,

    // downsampled pairs from the rx chains
    input  uberclock_pkg::iq_sample_t [`UC_NUM_CHAN-1:0]      i_rx_iq,
    input  logic [`UC_NUM_CHAN-1:0][`UC_GAIN_W-1:0]           i_gain,
    // cpu pair, common to all channels
    input  uberclock_pkg::iq_sample_t                         i_cpu_iq,
    input  logic                                              i_tx_src_cpu,

    // tx chain outputs coming back in
    input  logic signed [`UC_NUM_CHAN-1:0][`UC_SAMPLE_W-1:0]  i_tx_sample,
    input  logic [`UC_SHIFT_W-1:0]                            i_final_shift,

    // dac source codes
    input  uberclock_pkg::dac_src_e                           i_dac1_sel,
    input  uberclock_pkg::dac_src_e                           i_dac2_sel,

    // rx chain input
    output logic signed [`UC_ADC_W-1:0]                       o_rx_input,
    // feeds toward the tx chains
    output uberclock_pkg::iq_sample_t [`UC_NUM_CHAN-1:0]      o_tx_iq,
    output logic [`UC_DAC_W-1:0]                              o_dac1,
    output logic [`UC_DAC_W-1:0]                              o_dac2
);

    import uberclock_pkg::*;

    logic signed [`UC_ADC_W-1:0]               adc_ch0;
    logic signed [`UC_ADC_W-1:0]               adc_ch1;
    logic [`UC_NUM_CHAN-1:0][`UC_SAMPLE_W-1:0] gain_y;
    logic signed [`UC_DAC_W-1:0]               sum_trunc;
    logic signed [`UC_DAC_W-1:0]               loopback;
    dac_sources_t                              dac_src;

    // ------------------------------
    // adc capture and rx input
    // ------------------------------
    rx_source_select rx_source_select_i (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .i_adc_ch0      (i_adc_ch0),
        .i_adc_ch1      (i_adc_ch1),
        .i_use_loopback (i_use_loopback),
        .i_loopback     (loopback),
        .o_adc_ch0      (adc_ch0),
        .o_adc_ch1      (adc_ch1),
        .o_rx_input     (o_rx_input)
    );

    // ------------------------------
    // per channel tx feeds
    // ------------------------------
    // one gain stage per rx/tx pair
    for (genvar ch = 0; ch < `UC_NUM_CHAN; ch++) begin : g_feed
        tx_feed tx_feed_i (
            .i_rx      (i_rx_iq[ch]),
            .i_gain    (i_gain[ch]),
            .i_cpu     (i_cpu_iq),
            .i_src_cpu (i_tx_src_cpu),
            .o_feed    (o_tx_iq[ch]),
            .o_gain_y  (gain_y[ch])
        );
    end

    // ------------------------------
    // output sum
    // ------------------------------
    tx_sum_tree tx_sum_tree_i (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .i_tx_sample   (i_tx_sample),
        .i_final_shift (i_final_shift),
        .o_sum_trunc   (sum_trunc),
        .o_loopback    (loopback)
    );

    // ------------------------------
    // dac outputs
    // ------------------------------
    // shared source bundle, both dacs pick from it
    assign dac_src = '{
        gain_y:    gain_y,
        tx_sample: i_tx_sample,
        adc:       {adc_ch1, adc_ch0},
        sum_trunc: sum_trunc
    };

    dac_output_select dac1_select_i (
        .sys_clk (sys_clk),
        .rst     (rst),
        .i_sel   (i_dac1_sel),
        .i_src   (dac_src),
        .o_dac   (o_dac1)
    );

    dac_output_select dac2_select_i (
        .sys_clk (sys_clk),
        .rst     (rst),
        .i_sel   (i_dac2_sel),
        .i_src   (dac_src),
        .o_dac   (o_dac2)
    );

endmodule

/* rtl/uberclock_pkg.sv */
`include "uberclock_consts.svh"

package uberclock_pkg;

    // one complex sample, x is in-phase, y is quadrature
    typedef struct packed {
        logic signed [`UC_SAMPLE_W-1:0] x;
        logic signed [`UC_SAMPLE_W-1:0] y;
    } iq_sample_t;

    // dac source codes
    // code 10 was the nco cosine, it now lands on the sum
    typedef enum logic [3:0] {
        DAC_GAIN_Y0 = 4'd0,
        DAC_GAIN_Y1 = 4'd1,
        DAC_GAIN_Y2 = 4'd2,
        DAC_GAIN_Y3 = 4'd3,
        DAC_GAIN_Y4 = 4'd4,
        DAC_TX0     = 4'd5,
        DAC_TX1     = 4'd6,
        DAC_TX2     = 4'd7,
        DAC_TX3     = 4'd8,
        DAC_TX4     = 4'd9,
        DAC_SUM_10  = 4'd10,
        DAC_ADC0    = 4'd11,
        DAC_ADC1    = 4'd12,
        DAC_SUM     = 4'd13,
        DAC_SUM_14  = 4'd14,
        DAC_SUM_15  = 4'd15
    } dac_src_e;

    // everything either dac can show
    typedef struct packed {
        logic [`UC_NUM_CHAN-1:0][`UC_SAMPLE_W-1:0] gain_y;
        logic [`UC_NUM_CHAN-1:0][`UC_SAMPLE_W-1:0] tx_sample;
        logic [1:0][`UC_ADC_W-1:0]                 adc;
        logic [`UC_DAC_W-1:0]                      sum_trunc;
    } dac_sources_t;

endpackage

/* uberclock.f */
+incdir+include
rtl/uberclock_pkg.sv
rtl/rx_source_select.sv
rtl/tx_feed.sv
rtl/tx_sum_tree.sv
rtl/dac_output_select.sv
rtl/uberclock.sv
verif/uberclock_checker.sv
verif/uberclock_tb.sv

/* verif/uberclock_checker.sv */
`timescale 1ns/1ns
`include "uberclock_consts.svh"

module uberclock_checker (
    input  logic                                         sys_clk,
    // dut inputs as the testbench drives them
    input  logic [`UC_ADC_W-1:0]                         i_adc_ch0,
    input  logic [`UC_ADC_W-1:0]                         i_adc_ch1,
    input  logic                                         i_use_loopback,
    input  uberclock_pkg::iq_sample_t [`UC_NUM_CHAN-1:0] i_rx_iq,
    input  logic [`UC_NUM_CHAN-1:0][`UC_GAIN_W-1:0]      i_gain,
    input  uberclock_pkg::iq_sample_t                    i_cpu_iq,
    input  logic                                         i_tx_src_cpu,
    input  logic [`UC_NUM_CHAN-1:0][`UC_SAMPLE_W-1:0]    i_tx_sample,
    input  logic [`UC_SHIFT_W-1:0]                       i_final_shift,
    input  logic [3:0]                                   i_dac1_sel,
    input  logic [3:0]                                   i_dac2_sel,
    // dut outputs
    input  logic [`UC_ADC_W-1:0]                         i_rx_input,
    input  uberclock_pkg::iq_sample_t [`UC_NUM_CHAN-1:0] i_tx_iq,
    input  logic [`UC_DAC_W-1:0]                         i_dac1,
    input  logic [`UC_DAC_W-1:0]                         i_dac2,
    // sequencing strobes, all driven on falling edges
    input  logic                                         i_check,
    input  logic                                         i_test_end,
    input  logic                                         i_all_done,
    input  logic [2:0]                                   i_test_id,
    output int                                           o_bad_tests
);

    import uberclock_pkg::*;

    int checks = 0;
    int errors = 0;
    int tests_ok = 0;

    initial o_bad_tests = 0;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0: return "reset_state";
            3'd1: return "adc_conversion";
            3'd2: return "gain_path";
            3'd3: return "cpu_feed";
            3'd4: return "sum_truncation";
            default: return "loopback_shift";
        endcase
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    // offset binary zero sits at 0x800
    function automatic logic [`UC_ADC_W-1:0] adc_to_signed(input logic [`UC_ADC_W-1:0] raw);
        return raw ^ 12'h800;
    endfunction

    // sample times unsigned gain, /2^30 with sign kept, wraps to 16 bits
    function automatic logic [15:0] scale(input logic signed [15:0] s, input logic [31:0] g);
        longint prod;
        prod = longint'(s) * longint'(g);
        prod = prod >>> `UC_GAIN_SHIFT;
        return prod[15:0];
    endfunction

    // exact sum of five, then drop 5 lsbs
    function automatic logic [13:0] sum_trunc(input logic [4:0][15:0] t);
        int total;
        total = 0;
        for (int k = 0; k < `UC_NUM_CHAN; k++) begin
            total += int'($signed(t[k]));
        end
        total = total >>> `UC_SUM_DROP;
        return total[13:0];
    endfunction

    function automatic iq_sample_t tx_expect(input int ch);
        iq_sample_t e;
        if (i_tx_src_cpu) begin
            e = i_cpu_iq;
        end else begin
            e.x = scale(i_rx_iq[ch].x, i_gain[ch]);
            e.y = scale(i_rx_iq[ch].y, i_gain[ch]);
        end
        return e;
    endfunction

    function automatic logic [11:0] rx_expect();
        logic [13:0] lb;
        if (!i_use_loopback) begin
            return adc_to_signed(i_adc_ch0);
        end
        // shift wraps inside 14 bits, rx keeps the top 12
        lb = sum_trunc(i_tx_sample) << i_final_shift;
        return lb[13:2];
    endfunction

    function automatic logic [13:0] dac_expect(input logic [3:0] sel);
        logic [15:0] word;
        logic [13:0] pick;
        // right after reset the dac still shows midscale
        if (i_test_id == 3'd0) begin
            return 14'(`UC_DAC_MIDSCALE);
        end
        if (sel <= 4'd4) begin
            word = scale(i_rx_iq[sel].y, i_gain[sel]);
            pick = word[15:2];
        end else if (sel <= 4'd9) begin
            word = i_tx_sample[sel - 4'd5];
            pick = word[15:2];
        end else if (sel == 4'd11) begin
            pick = {adc_to_signed(i_adc_ch0), 2'b00};
        end else if (sel == 4'd12) begin
            pick = {adc_to_signed(i_adc_ch1), 2'b00};
        end else begin
            pick = sum_trunc(i_tx_sample);
        end
        return pick + 14'(`UC_DAC_MIDSCALE);
    endfunction

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s %s: expected %0h actual %0h",
                     test_name(i_test_id), what, exp, act);
        end
    endtask

    // ------------------------------
    // comparison process
    // ------------------------------
    // sampled on the rising edge, registers still show the settled values
    always @(posedge sys_clk) begin
        if (i_check) begin
            compare_value("o_rx_input", rx_expect(), i_rx_input);
            for (int ch = 0; ch < `UC_NUM_CHAN; ch++) begin
                compare_value($sformatf("o_tx_iq[%0d]", ch), tx_expect(ch), i_tx_iq[ch]);
            end
            compare_value("o_dac1", dac_expect(i_dac1_sel), i_dac1);
            compare_value("o_dac2", dac_expect(i_dac2_sel), i_dac2);
        end
        if (i_test_end) begin
            if (errors == 0) begin
                tests_ok++;
            end else begin
                o_bad_tests++;
            end
            $display("%-16s %-4s %0d checks, %0d errors", test_name(i_test_id),
                     (errors == 0) ? "ok" : "FAIL", checks, errors);
            checks = 0;
            errors = 0;
        end
        if (i_all_done) begin
            $display("tests ok %0d, tests with errors %0d", tests_ok, o_bad_tests);
        end
    end

endmodule

/* verif/uberclock_tb.sv */
`timescale 1ns/1ns
`include "uberclock_consts.svh"

module uberclock_tb;

    import uberclock_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 6;
    localparam int NUM_VEC    = 20;
    localparam int HOLD_CYC   = 8;
    // twice the nominal run
    localparam int TIMEOUT_NS = NUM_TESTS * NUM_VEC * HOLD_CYC * CLK_PERIOD * 2;

    logic                                      sys_clk;
    logic                                      rst;
    logic [`UC_ADC_W-1:0]                      adc_ch0;
    logic [`UC_ADC_W-1:0]                      adc_ch1;
    logic                                      use_loopback;
    iq_sample_t [`UC_NUM_CHAN-1:0]             rx_iq;
    logic [`UC_NUM_CHAN-1:0][`UC_GAIN_W-1:0]   gain;
    iq_sample_t                                cpu_iq;
    logic                                      tx_src_cpu;
    logic [`UC_NUM_CHAN-1:0][`UC_SAMPLE_W-1:0] tx_sample;
    logic [`UC_SHIFT_W-1:0]                    final_shift;
    dac_src_e                                  dac1_sel;
    dac_src_e                                  dac2_sel;
    logic [`UC_ADC_W-1:0]                      rx_input;
    iq_sample_t [`UC_NUM_CHAN-1:0]             tx_iq;
    logic [`UC_DAC_W-1:0]                      dac1;
    logic [`UC_DAC_W-1:0]                      dac2;
    // checker strobes
    logic                                      check_req;
    logic                                      test_end;
    logic                                      all_done;
    logic [2:0]                                test_id;
    int                                        bad_tests;

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    uberclock uberclock_i (
        .sys_clk (sys_clk), .rst (rst),
        .i_adc_ch0 (adc_ch0), .i_adc_ch1 (adc_ch1), .i_use_loopback (use_loopback),
        .i_rx_iq (rx_iq), .i_gain (gain), .i_cpu_iq (cpu_iq), .i_tx_src_cpu (tx_src_cpu),
        .i_tx_sample (tx_sample), .i_final_shift (final_shift),
        .i_dac1_sel (dac1_sel), .i_dac2_sel (dac2_sel),
        .o_rx_input (rx_input), .o_tx_iq (tx_iq), .o_dac1 (dac1), .o_dac2 (dac2)
    );

    uberclock_checker checker_i (
        .sys_clk (sys_clk),
        .i_adc_ch0 (adc_ch0), .i_adc_ch1 (adc_ch1), .i_use_loopback (use_loopback),
        .i_rx_iq (rx_iq), .i_gain (gain), .i_cpu_iq (cpu_iq), .i_tx_src_cpu (tx_src_cpu),
        .i_tx_sample (tx_sample), .i_final_shift (final_shift),
        .i_dac1_sel (dac1_sel), .i_dac2_sel (dac2_sel),
        .i_rx_input (rx_input), .i_tx_iq (tx_iq), .i_dac1 (dac1), .i_dac2 (dac2),
        .i_check (check_req), .i_test_end (test_end), .i_all_done (all_done),
        .i_test_id (test_id), .o_bad_tests (bad_tests)
    );

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic randomize_data();
        adc_ch0     = 12'($urandom);
        adc_ch1     = 12'($urandom);
        cpu_iq      = $urandom;
        final_shift = 3'($urandom);
        for (int ch = 0; ch < `UC_NUM_CHAN; ch++) begin
            rx_iq[ch]     = $urandom;
            gain[ch]      = $urandom;
            tx_sample[ch] = 16'($urandom);
        end
    endtask

    // checker samples in the last cycle of the hold
    task automatic hold_and_check();
        repeat (HOLD_CYC - 1) @(negedge sys_clk);
        check_req = 1'b1;
        @(negedge sys_clk);
        check_req = 1'b0;
    endtask

    task automatic end_test();
        test_end = 1'b1;
        @(negedge sys_clk);
        test_end = 1'b0;
    endtask

    task automatic run_test(input logic [2:0] id);
        test_id = id;
        for (int v = 0; v < NUM_VEC; v++) begin
            randomize_data();
            use_loopback = (id == 3'd5);
            tx_src_cpu   = (id == 3'd3);
            case (id)
                3'd1: begin
                    dac1_sel = DAC_ADC0;
                    dac2_sel = DAC_ADC1;
                end
                3'd2, 3'd3: begin
                    dac1_sel = dac_src_e'($urandom_range(4, 0));
                    dac2_sel = dac_src_e'($urandom_range(4, 0));
                end
                3'd4: begin
                    dac1_sel = DAC_SUM;
                    dac2_sel = dac_src_e'($urandom_range(9, 5));
                end
                default: begin
                    // any code including the sum aliases
                    dac1_sel = dac_src_e'($urandom_range(15, 0));
                    dac2_sel = dac_src_e'($urandom_range(15, 0));
                end
            endcase
            hold_and_check();
        end
        end_test();
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        void'($urandom(83));
        sys_clk      = 1'b0;
        rst          = 1'b1;
        check_req    = 1'b0;
        test_end     = 1'b0;
        all_done     = 1'b0;
        test_id      = 3'd0;
        use_loopback = 1'b0;
        tx_src_cpu   = 1'b0;
        dac1_sel     = DAC_SUM;
        dac2_sel     = DAC_SUM;
        randomize_data();
        repeat (5) @(negedge sys_clk);
        rst = 1'b0;
        // first edge out of reset captures the adc while the sum stays zero
        @(negedge sys_clk);
        check_req = 1'b1;
        @(negedge sys_clk);
        check_req = 1'b0;
        end_test();
        for (int id = 1; id < NUM_TESTS; id++) begin
            run_test(3'(id));
        end
        all_done = 1'b1;
        @(negedge sys_clk);
        all_done = 1'b0;
        if (bad_tests == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not complete within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

endmodule
